// ==== include/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
`define DCACHE_WAYS 4
`define DCACHE_INDEX_W 4
`define DCACHE_OFFSET_W 4

// one line is one burst
`define DCACHE_WORDS 4

// address split, tag is what remains above index and offset
`define DCACHE_TAG_W (32 - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`endif

// ==== hw/dcache_pkg.sv ====
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t;      // byte address
    typedef logic [31:0] word_t;
    typedef logic [3:0] be_t;         // byte enable, zero means load

    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [1:0] word_sel_t;   // word within a line
    typedef logic [1:0] way_t;
    typedef logic [`DCACHE_WAYS-1:0] way_mask_t;

    // miss path goes compare -> [wb_req -> wait_mem] -> refill_req -> wait_mem -> lookup
    typedef enum logic [2:0] {
        idle,
        lookup,
        compare,
        wb_req,
        refill_req,
        wait_mem
    } ctrl_state_t;

endpackage

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             cpu_req,
    input  dcache_pkg::be_t  cpu_wen,
    input  logic             hit,
    input  logic             victim_dirty,
    input  logic             wb_done,
    input  logic             refill_done,
    output logic             cpu_done,
    output logic             rd_en,
    output logic             hit_wr_en,
    output logic             lru_touch,
    output logic             wb_start,
    output logic             refill_start,
    output logic             fill_en
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_next;
    logic wb_phase;   // wait_mem belongs to the write-back

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::idle: begin
                if (cpu_req) begin
                    state_next = dcache_pkg::lookup;
                end
            end
            dcache_pkg::lookup: state_next = dcache_pkg::compare;   // arrays read here
            dcache_pkg::compare: begin
                if (hit) begin
                    state_next = dcache_pkg::idle;
                end else if (victim_dirty) begin
                    state_next = dcache_pkg::wb_req;
                end else begin
                    state_next = dcache_pkg::refill_req;
                end
            end
            dcache_pkg::wb_req: state_next = dcache_pkg::wait_mem;
            dcache_pkg::refill_req: state_next = dcache_pkg::wait_mem;
            dcache_pkg::wait_mem: begin
                if (wb_phase && wb_done) begin
                    state_next = dcache_pkg::refill_req;
                end else if (!wb_phase && refill_done) begin
                    // replay, the lookup will hit now
                    state_next = dcache_pkg::lookup;
                end
            end
            default: state_next = dcache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::idle;
            wb_phase <= 1'b0;
        end else begin
            state <= state_next;
            if (state == dcache_pkg::wb_req) begin
                wb_phase <= 1'b1;
            end else if (state == dcache_pkg::refill_req) begin
                wb_phase <= 1'b0;
            end
        end
    end

    assign rd_en = (state == dcache_pkg::lookup);
    assign cpu_done = (state == dcache_pkg::compare) && hit;
    assign hit_wr_en = cpu_done && (|cpu_wen);   // store merge on hit
    assign lru_touch = cpu_done;
    assign wb_start = (state == dcache_pkg::wb_req);
    assign refill_start = (state == dcache_pkg::refill_req);

    // open window for refill beats until the last one lands
    assign fill_en = refill_start || ((state == dcache_pkg::wait_mem) && !wb_phase);

endmodule

// ==== hw/dcache_tag_store.sv ====
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_tag_store (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_en,
    input  dcache_pkg::addr_t  cpu_addr,
    input  logic               fill_done,
    input  dcache_pkg::way_t   victim_way,
    input  logic               hit_wr_en,
    output logic               hit,
    output dcache_pkg::way_t   hit_way,
    output logic               victim_dirty,
    output dcache_pkg::tag_t   victim_tag
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    dcache_pkg::tag_t tag_mem [`DCACHE_WAYS][SETS];
    logic [SETS-1:0] valid_q [`DCACHE_WAYS];
    logic [SETS-1:0] dirty_q [`DCACHE_WAYS];

    dcache_pkg::tag_t tag_r [`DCACHE_WAYS];   // registered lookup result
    dcache_pkg::way_mask_t valid_r;
    dcache_pkg::way_mask_t dirty_r;
    dcache_pkg::way_mask_t hit_mask;

    dcache_pkg::tag_t addr_tag;
    dcache_pkg::index_t index;

    assign addr_tag = cpu_addr[31 -: `DCACHE_TAG_W];
    assign index = cpu_addr[`DCACHE_INDEX_W+`DCACHE_OFFSET_W-1 : `DCACHE_OFFSET_W];

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                tag_r[w] <= tag_mem[w][index];
            end
        end
        if (fill_done) begin
            tag_mem[victim_way][index] <= addr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            valid_r <= '0;
            dirty_r <= '0;
        end else begin
            if (rd_en) begin
                for (int w = 0; w < `DCACHE_WAYS; w++) begin
                    valid_r[w] <= valid_q[w][index];
                    dirty_r[w] <= dirty_q[w][index];
                end
            end
            if (fill_done) begin   // fresh line, clean
                valid_q[victim_way][index] <= 1'b1;
                dirty_q[victim_way][index] <= 1'b0;
            end
            if (hit_wr_en) begin
                dirty_q[hit_way][index] <= 1'b1;
            end
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_mask[w] = valid_r[w] && (tag_r[w] == addr_tag);
            if (hit_mask[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign hit = |hit_mask;
    assign victim_dirty = valid_r[victim_way] && dirty_r[victim_way];
    assign victim_tag = tag_r[victim_way];   // write-back address

endmodule

// ==== hw/dcache_data_store.sv ====
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_data_store (
    input  logic                   clk,
    input  logic                   rd_en,
    input  dcache_pkg::addr_t      cpu_addr,
    input  dcache_pkg::be_t        cpu_wen,
    input  dcache_pkg::word_t      cpu_wdata,
    input  logic                   hit_wr_en,
    input  dcache_pkg::way_t       hit_way,
    input  logic                   fill_en,
    input  dcache_pkg::way_t       victim_way,
    input  dcache_pkg::word_sel_t  beat,
    input  logic                   beat_we,
    input  dcache_pkg::word_t      rdata,
    output dcache_pkg::word_t      cpu_rdata,
    output dcache_pkg::word_t      victim_word
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    dcache_pkg::word_t mem [`DCACHE_WAYS][`DCACHE_WORDS][SETS];
    dcache_pkg::word_t line_r [`DCACHE_WAYS][`DCACHE_WORDS];   // all ways of the set

    dcache_pkg::index_t index;
    dcache_pkg::word_sel_t word_sel;

    assign index = cpu_addr[`DCACHE_INDEX_W+`DCACHE_OFFSET_W-1 : `DCACHE_OFFSET_W];
    assign word_sel = cpu_addr[`DCACHE_OFFSET_W-1 : 2];

    always_ff @(posedge clk) begin
        if (fill_en && beat_we) begin
            mem[victim_way][beat][index] <= rdata;   // refill beat lands same cycle
        end else if (hit_wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (cpu_wen[b]) begin
                    mem[hit_way][word_sel][index][8*b +: 8] <= cpu_wdata[8*b +: 8];
                end
            end
        end
        if (rd_en) begin
            for (int w = 0; w < `DCACHE_WAYS; w++) begin
                for (int k = 0; k < `DCACHE_WORDS; k++) begin
                    line_r[w][k] <= mem[w][k][index];
                end
            end
        end
    end

    assign cpu_rdata = line_r[hit_way][word_sel];
    assign victim_word = line_r[victim_way][beat];   // follows the W beat count

endmodule

// ==== hw/dcache_plru.sv ====
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_plru (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::index_t  index,
    input  logic                lru_touch,
    input  dcache_pkg::way_t    touch_way,
    output dcache_pkg::way_t    victim_way
);

    localparam int SETS = 1 << `DCACHE_INDEX_W;

    // bit 0 picks the half, bit 1 the low pair, bit 2 the high pair
    logic [`DCACHE_WAYS-2:0] tree_q [SETS];
    logic [`DCACHE_WAYS-2:0] cur;

    assign cur = tree_q[index];
    assign victim_way = {cur[0], cur[0] ? cur[2] : cur[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (lru_touch) begin
            tree_q[index][0] <= ~touch_way[1];   // point at the other half
            if (touch_way[1]) begin
                tree_q[index][2] <= ~touch_way[0];
            end else begin
                tree_q[index][1] <= ~touch_way[0];
            end
        end
    end

endmodule

// ==== hw/dcache_axi_port.sv ====
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_axi_port (
    input  logic                   clk,
    input  logic                   rst,
    input  dcache_pkg::addr_t      cpu_addr,
    input  dcache_pkg::tag_t       victim_tag,
    input  dcache_pkg::word_t      victim_word,
    input  logic                   wb_start,
    input  logic                   refill_start,
    output dcache_pkg::addr_t      araddr,
    output logic                   arvalid,
    input  logic                   arready,
    input  logic                   rvalid,
    input  logic                   rlast,
    output logic                   rready,
    output dcache_pkg::addr_t      awaddr,
    output logic                   awvalid,
    input  logic                   awready,
    output dcache_pkg::word_t      wdata,
    output dcache_pkg::be_t        wstrb,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready,
    output dcache_pkg::word_sel_t  beat,
    output logic                   beat_we,
    output logic                   wb_done,
    output logic                   refill_done
);

    logic rd_active;   // refill burst in flight
    logic ar_sent;
    logic wr_active;
    logic aw_sent;
    logic w_done;      // last W beat accepted, waiting on B
    dcache_pkg::word_sel_t rcnt;
    dcache_pkg::word_sel_t wcnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_active <= 1'b0;
            ar_sent <= 1'b0;
            rcnt <= '0;
        end else begin
            if (refill_start) begin
                rd_active <= 1'b1;
                rcnt <= '0;
            end else if (refill_done) begin
                rd_active <= 1'b0;
                ar_sent <= 1'b0;
            end
            if (arvalid && arready) begin
                ar_sent <= 1'b1;
            end
            if (beat_we) begin
                rcnt <= rcnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_active <= 1'b0;
            aw_sent <= 1'b0;
            w_done <= 1'b0;
            wcnt <= '0;
        end else begin
            if (wb_start) begin
                wr_active <= 1'b1;
                wcnt <= '0;
            end else if (wb_done) begin
                wr_active <= 1'b0;
                aw_sent <= 1'b0;
                w_done <= 1'b0;
            end
            if (awvalid && awready) begin
                aw_sent <= 1'b1;
            end
            if (wvalid && wready) begin
                wcnt <= wcnt + 2'd1;
                w_done <= wlast;
            end
        end
    end

    // line-aligned addresses
    assign araddr = {cpu_addr[31:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}};
    assign awaddr = {victim_tag,
                     cpu_addr[`DCACHE_INDEX_W+`DCACHE_OFFSET_W-1 : `DCACHE_OFFSET_W],
                     {`DCACHE_OFFSET_W{1'b0}}};

    assign arvalid = rd_active && !ar_sent;
    assign rready = rd_active && ar_sent;
    assign beat_we = rvalid && rready;
    assign refill_done = beat_we && rlast;

    assign awvalid = wr_active && !aw_sent;
    assign wvalid = aw_sent && !w_done;
    assign wdata = victim_word;
    assign wstrb = '1;   // whole line goes back
    assign wlast = (wcnt == dcache_pkg::word_sel_t'(`DCACHE_WORDS - 1));
    assign bready = w_done;
    assign wb_done = bvalid && bready;

    assign beat = rd_active ? rcnt : wcnt;

endmodule

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ns
`include "dcache_settings.svh"

module dcache_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_req,
    input  dcache_pkg::addr_t  cpu_addr,
    input  dcache_pkg::be_t    cpu_wen,
    input  dcache_pkg::word_t  cpu_wdata,
    output logic               cpu_done,
    output dcache_pkg::word_t  cpu_rdata,
    output dcache_pkg::addr_t  araddr,
    output logic               arvalid,
    input  logic               arready,
    input  dcache_pkg::word_t  rdata,
    input  logic               rlast,
    input  logic               rvalid,
    output logic               rready,
    output dcache_pkg::addr_t  awaddr,
    output logic               awvalid,
    input  logic               awready,
    output dcache_pkg::word_t  wdata,
    output dcache_pkg::be_t    wstrb,
    output logic               wlast,
    output logic               wvalid,
    input  logic               wready,
    input  logic               bvalid,
    output logic               bready
);

    logic rd_en;
    logic fill_en;
    logic hit_wr_en;
    logic lru_touch;
    logic wb_start;
    logic refill_start;
    logic hit;
    logic victim_dirty;
    logic wb_done;
    logic refill_done;
    logic beat_we;
    dcache_pkg::way_t hit_way;
    dcache_pkg::way_t victim_way;
    dcache_pkg::tag_t victim_tag;
    dcache_pkg::word_t victim_word;
    dcache_pkg::word_sel_t beat;

    dcache_ctrl ctrl_i (
        .clk(clk), .rst(rst), .cpu_req(cpu_req), .cpu_wen(cpu_wen),
        .hit(hit), .victim_dirty(victim_dirty),
        .wb_done(wb_done), .refill_done(refill_done),
        .cpu_done(cpu_done), .rd_en(rd_en), .hit_wr_en(hit_wr_en),
        .lru_touch(lru_touch), .wb_start(wb_start),
        .refill_start(refill_start), .fill_en(fill_en)
    );

    dcache_tag_store tag_store_i (
        .clk(clk), .rst(rst), .rd_en(rd_en), .cpu_addr(cpu_addr),
        .fill_done(refill_done), .victim_way(victim_way), .hit_wr_en(hit_wr_en),
        .hit(hit), .hit_way(hit_way), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    dcache_data_store data_store_i (
        .clk(clk), .rd_en(rd_en), .cpu_addr(cpu_addr), .cpu_wen(cpu_wen),
        .cpu_wdata(cpu_wdata), .hit_wr_en(hit_wr_en), .hit_way(hit_way),
        .fill_en(fill_en), .victim_way(victim_way), .beat(beat),
        .beat_we(beat_we), .rdata(rdata),
        .cpu_rdata(cpu_rdata), .victim_word(victim_word)
    );

    // touched way is always the hit way, refills get touched on replay
    dcache_plru plru_i (
        .clk(clk), .rst(rst),
        .index(cpu_addr[`DCACHE_INDEX_W+`DCACHE_OFFSET_W-1 : `DCACHE_OFFSET_W]),
        .lru_touch(lru_touch), .touch_way(hit_way), .victim_way(victim_way)
    );

    dcache_axi_port axi_port_i (
        .clk(clk), .rst(rst), .cpu_addr(cpu_addr), .victim_tag(victim_tag),
        .victim_word(victim_word), .wb_start(wb_start), .refill_start(refill_start),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rvalid(rvalid), .rlast(rlast), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid),
        .wready(wready), .bvalid(bvalid), .bready(bready),
        .beat(beat), .beat_we(beat_we), .wb_done(wb_done), .refill_done(refill_done)
    );

endmodule

// ==== verif/dcache_properties.sv ====
`timescale 1ns/1ns

module dcache_properties (
    input logic        clk,
    input logic        rst,
    input logic        cpu_done,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] awaddr,
    input logic        wvalid,
    input logic        wready,
    input logic [31:0] wdata,
    input logic        wlast
);

    // a raised valid keeps its payload until taken
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR valid or address changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW valid or address changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("W valid or data changed before wready");

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_done |=> !cpu_done)
        else $error("cpu_done high for two cycles");

    // write-back and refill are serialized
    no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid))
        else $error("arvalid and awvalid high together");

endmodule

bind dcache_top dcache_properties dcache_properties_i (
    .clk(clk), .rst(rst), .cpu_done(cpu_done),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wlast(wlast)
);

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ns

module dcache_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_REQ = 2000;
    localparam int FLUSH_REQ = 64;        // four fresh lines for each of the 16 sets
    localparam int MEM_WORDS = 2048;      // 8 KB covers the request window and the flush region
    localparam int CYCLES_PER_REQ = 200;
    localparam int WATCHDOG_NS =
        (RESET_CYCLES + (NUM_REQ + FLUSH_REQ) * CYCLES_PER_REQ) * CLK_PERIOD;

    logic clk;
    logic rst;
    logic cpu_req;
    logic [31:0] cpu_addr;
    logic [3:0] cpu_wen;
    logic [31:0] cpu_wdata;
    logic cpu_done;
    logic [31:0] cpu_rdata;
    logic [31:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic rlast;
    logic rvalid;
    logic rready;
    logic [31:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic [3:0] wstrb;
    logic wlast;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;

    integer seed;
    integer slave_seed;

    logic [31:0] model_mem [MEM_WORDS];   // reference model with every store applied on done
    logic [31:0] slave_mem [MEM_WORDS];   // what the memory side really holds

    // memory slave burst state where beat count 4 means idle
    logic [31:0] rd_base;
    int rd_beat;
    logic r_fire;
    logic [31:0] wr_base;
    int wr_beat;
    logic b_pending;
    logic b_fire;

    dcache_top dcache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s = %h, expected %h", name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // odd multiplier makes the fill unique per byte address
    function automatic logic [31:0] fill_word(input int unsigned byte_addr);
        return (byte_addr * 32'h9e37_79b1) ^ 32'h0bad_f00d;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic int word_index(input logic [31:0] base, input int beat);
        return int'(base[12:2]) + beat;
    endfunction

    // ready or valid about three times in four
    function automatic logic coin_flip();
        integer r;
        r = $random(slave_seed);
        return r[1:0] != 2'b00;
    endfunction

    task automatic init_inputs();
        rst = 1'b1;
        cpu_req = 1'b0;
        cpu_addr = 32'h0;
        cpu_wen = 4'h0;
        cpu_wdata = 32'h0;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = 32'h0;
        rlast = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
    endtask

    task automatic check_reset_outputs();
        check_value("cpu_done", 32'(cpu_done), 32'h0);
        check_value("arvalid", 32'(arvalid), 32'h0);
        check_value("awvalid", 32'(awvalid), 32'h0);
        check_value("wvalid", 32'(wvalid), 32'h0);
        check_value("rready", 32'(rready), 32'h0);
        check_value("bready", 32'(bready), 32'h0);
    endtask

    // transfers decided at this negedge land on the next posedge
    task automatic serve_memory_cycle();
        if (b_fire) begin
            bvalid = 1'b0;
            b_pending = 1'b0;
        end
        if (b_pending && !bvalid) begin
            bvalid = coin_flip();   // B only after the last W beat has gone
        end
        b_fire = bvalid && bready;

        wready = coin_flip();
        if (wvalid && wready) begin
            check_value("w beat below 4", 32'(wr_beat < 4), 32'h1);
            check_value("wstrb", 32'(wstrb), 32'hf);
            check_value("wlast", 32'(wlast), 32'(wr_beat == 3));
            check_value("wdata", wdata, model_mem[word_index(wr_base, wr_beat)]);
            slave_mem[word_index(wr_base, wr_beat)] = wdata;
            if (wr_beat == 3) begin
                b_pending = 1'b1;
            end
            wr_beat = wr_beat + 1;
        end

        awready = coin_flip();
        if (awvalid && awready) begin
            check_value("awaddr[3:0]", 32'(awaddr[3:0]), 32'h0);
            check_value("w beats of last burst", 32'(wr_beat), 32'd4);
            wr_base = awaddr;
            wr_beat = 0;
        end

        if (r_fire) begin
            rd_beat = rd_beat + 1;
            rvalid = 1'b0;
        end
        if (rd_beat < 4 && !rvalid) begin
            rvalid = coin_flip();
            rdata = slave_mem[word_index(rd_base, rd_beat)];
            rlast = (rd_beat == 3);
        end
        r_fire = rvalid && rready;

        arready = coin_flip();
        if (arvalid && arready) begin
            check_value("araddr[3:0]", 32'(araddr[3:0]), 32'h0);
            check_value("r beats of last burst", 32'(rd_beat), 32'd4);
            rd_base = araddr;
            rd_beat = 0;
        end
    endtask

    initial begin
        slave_seed = 84;
        rd_base = 32'h0;
        rd_beat = 4;
        r_fire = 1'b0;
        wr_base = 32'h0;
        wr_beat = 4;
        b_pending = 1'b0;
        b_fire = 1'b0;
        wait (rst == 1'b0);   // serving starts one negedge after reset drops
        forever begin
            @(negedge clk);
            serve_memory_cycle();
        end
    end

    // present one request, hold it until done, then check or apply it to the model
    task automatic run_request(input logic [31:0] addr, input logic [3:0] wen,
                               input logic [31:0] wr_word, output int cycles);
        @(negedge clk);
        cpu_req = 1'b1;
        cpu_addr = addr;
        cpu_wen = wen;
        cpu_wdata = wr_word;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles = cycles + 1;
        end while (!cpu_done);
        if (wen == 4'h0) begin
            check_value("cpu_rdata", cpu_rdata, model_mem[addr[12:2]]);
        end else begin
            model_mem[addr[12:2]] = merge_bytes(model_mem[addr[12:2]], wr_word, wen);
        end
    endtask

    initial begin
        integer r;
        int cycles;
        logic [31:0] addr;
        logic [31:0] prev_addr;
        logic [3:0] wen;
        logic [31:0] wr_word;

        seed = 84;
        init_inputs();
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = fill_word(i * 4);
            slave_mem[i] = model_mem[i];
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_reset_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        check_reset_outputs();

        prev_addr = 32'h0;
        for (int n = 0; n < NUM_REQ; n++) begin
            r = $random(seed);
            if (n > 0 && r[2:0] == 3'd0) begin
                // repeat of the last word must hit in two cycles
                run_request(prev_addr, 4'h0, 32'h0, cycles);
                check_value("hit latency", cycles, 32'd2);
            end else begin
                addr = {21'h0, r[16:8], 2'b00};   // 8 lines per set in the 2 KB window
                wen = r[20] ? r[24:21] : 4'h0;
                wr_word = $random(seed);
                run_request(addr, wen, wr_word, cycles);
                prev_addr = addr;
            end
        end

        // four new lines per set push every old line out
        for (int s = 0; s < 16; s++) begin
            for (int k = 0; k < 4; k++) begin
                addr = 32'h1000 + k * 32'h100 + s * 32'h10;
                run_request(addr, 4'h0, 32'h0, cycles);
            end
        end
        @(negedge clk);
        cpu_req = 1'b0;

        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("slave_mem[%0d]", i), slave_mem[i], model_mem[i]);
        end

        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the cache stopped completing requests");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== dcache.f ====
+incdir+include
hw/dcache_pkg.sv
hw/dcache_ctrl.sv
hw/dcache_tag_store.sv
hw/dcache_data_store.sv
hw/dcache_plru.sv
hw/dcache_axi_port.sv
hw/dcache_top.sv
verif/dcache_properties.sv
verif/dcache_tb.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f dcache.f --top-module dcache_tb -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f dcache.f --top-module dcache_tb

clean:
	rm -rf obj_dir sim.log
